// File: sld_pkg.sv
/* widths are fixed here; the slide unit only works at VREG_W = 128 and SLD_OP_W = 32
   unless these constants and the counter layout are edited together */
package sld_pkg;

    localparam int unsigned VREG_W   = 128;
    localparam int unsigned SLD_OP_W = 32;
    localparam int unsigned CHUNKS   = VREG_W / SLD_OP_W;
    localparam int unsigned SHFT_W   = 2;
    localparam int unsigned VL_W     = 5;
    localparam int unsigned CNT_W    = 4;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sld_sew_e;

    // destination chunk position, counted up once per issued chunk
    // ext and mul together flag a position outside the register
    typedef union packed {
        logic [CNT_W-1:0] val;
        struct packed {
            logic       ext;
            logic       mul;
            logic [1:0] low;
        } part;
    } sld_counter_u;

    typedef struct packed {
        sld_op_e                        op;
        sld_sew_e                       eew;
        logic [VL_W-1:0]                vl;
        logic [$clog2(VREG_W/8)-1:0]    slide;
        logic                           in_range;
    } sld_cmd_t;

    typedef struct packed {
        logic                   valid;
        logic [SLD_OP_W-1:0]    data;
        sld_counter_u           count_store;
        logic [SHFT_W-1:0]      op_shift;
        logic                   first;
        logic                   last;
        logic                   beyond;
        sld_op_e                op;
        sld_sew_e               eew;
        logic [VL_W-1:0]        vl;
    } sld_chunk_t;

    typedef struct packed {
        logic                   valid;
        logic [SLD_OP_W-1:0]    low;
        logic [SLD_OP_W-1:0]    high;
        logic                   low_valid;
        logic                   high_valid;
        sld_counter_u           count_store;
        logic [SHFT_W-1:0]      op_shift;
        logic                   first;
        logic                   last;
        sld_op_e                op;
        sld_sew_e               eew;
        logic [VL_W-1:0]        vl;
    } sld_pair_t;

endpackage

// File: sld_operand_seq.sv
/* accepts one slide operation while idle or in its last issue cycle;
   every operation issues 2*CHUNKS chunks, the inputs must hold steady while op_rdy_i is high */
module sld_operand_seq (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,
    input  logic                        op_rdy_i,
    input  sld_pkg::sld_op_e            op_i,
    input  sld_pkg::sld_sew_e           sew_i,
    input  logic [31:0]                 rs1_i,
    input  logic [sld_pkg::VL_W-1:0]    vl_i,
    input  logic [sld_pkg::VREG_W-1:0]  src_i,
    output logic                        op_ack_o,
    output sld_pkg::sld_chunk_t         chunk_o
);

    localparam int unsigned IDX_W = $clog2(sld_pkg::CHUNKS);

    logic                               busy_q;
    logic [sld_pkg::CNT_W-1:0]          cnt_q;
    sld_pkg::sld_cmd_t                  cmd_q;
    logic [sld_pkg::VREG_W-1:0]         src_q;
    logic                               last_cycle;
    logic                               accept;
    logic [$clog2(sld_pkg::VREG_W/8)-1:0] byte_slide;
    logic                               in_range;
    sld_pkg::sld_counter_u              start;
    sld_pkg::sld_counter_u              count_store;
    logic [sld_pkg::SHFT_W-1:0]         op_shift;

    //////////////////////////////
    // acceptance

    // rs1 scaled to bytes, anything at or past 16 bytes is out of range
    always_comb begin
        unique case (sew_i)
            sld_pkg::SEW_8: begin
                byte_slide = rs1_i[3:0];
                in_range   = rs1_i[31:4] == '0;
            end
            sld_pkg::SEW_16: begin
                byte_slide = {rs1_i[2:0], 1'b0};
                in_range   = rs1_i[31:3] == '0;
            end
            default: begin
                byte_slide = {rs1_i[1:0], 2'b00};
                in_range   = rs1_i[31:2] == '0;
            end
        endcase
    end

    assign last_cycle = busy_q & (cnt_q == sld_pkg::CNT_W'(2 * sld_pkg::CHUNKS - 1));
    assign accept     = op_rdy_i & (~busy_q | last_cycle);
    assign op_ack_o   = accept;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            cmd_q  <= '0;
        end else if (accept) begin
            busy_q         <= 1'b1;
            cnt_q          <= '0;
            cmd_q.op       <= op_i;
            cmd_q.eew      <= sew_i;
            cmd_q.vl       <= vl_i;
            cmd_q.slide    <= byte_slide;
            cmd_q.in_range <= in_range;
        end else if (busy_q) begin
            busy_q <= ~last_cycle;
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    // an out-of-range slide reads only zeros
    always_ff @(posedge clk_i) begin
        if (accept) begin
            src_q <= in_range ? src_i : '0;
        end
    end

    //////////////////////////////
    // counter start and shift

    // up starts at the chunk offset, one earlier when chunk aligned
    // down starts below zero so the first stored chunk sits at position 0
    always_comb begin
        if (!cmd_q.in_range) begin
            start.val = (cmd_q.op == sld_pkg::SLD_UP) ? 4'b1000 : 4'b1111;
            op_shift  = '0;
        end else if (cmd_q.op == sld_pkg::SLD_UP) begin
            start.val = {2'b00, cmd_q.slide[3:2]}
                        - ((cmd_q.slide[1:0] == 2'b00) ? 4'd1 : 4'd0);
            op_shift  = -cmd_q.slide[1:0];
        end else begin
            start.val = {2'b11, ~cmd_q.slide[3:2]};
            op_shift  = cmd_q.slide[1:0];
        end
    end

    assign count_store.val = start.val + cnt_q;

    //////////////////////////////
    // chunk issue

    always_comb begin
        chunk_o.valid       = busy_q;
        chunk_o.data        = src_q[cnt_q[IDX_W-1:0]*sld_pkg::SLD_OP_W +: sld_pkg::SLD_OP_W];
        chunk_o.count_store = count_store;
        chunk_o.op_shift    = op_shift;
        chunk_o.first       = busy_q & (cnt_q == '0);
        chunk_o.last        = last_cycle;
        chunk_o.beyond      = cnt_q >= sld_pkg::CNT_W'(sld_pkg::CHUNKS);
        chunk_o.op          = cmd_q.op;
        chunk_o.eew         = cmd_q.eew;
        chunk_o.vl          = cmd_q.vl;
    end

endmodule

// File: sld_operand_win.sv
/* one register stage; the low operand is the high operand of the cycle before */
module sld_operand_win (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  sld_pkg::sld_chunk_t   chunk_i,
    output sld_pkg::sld_pair_t    pair_o
);

    sld_pkg::sld_pair_t            pair_q;
    logic [sld_pkg::SLD_OP_W-1:0]  high_d;
    logic                          is_down;

    assign is_down = chunk_i.op == sld_pkg::SLD_DOWN;

    // slide-down reads zeros past the end of the register
    assign high_d = (is_down & chunk_i.beyond) ? '0 : chunk_i.data;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            pair_q <= '0;
        end else begin
            pair_q.valid       <= chunk_i.valid;
            pair_q.low         <= pair_q.high;
            pair_q.high        <= high_d;
            pair_q.low_valid   <= ~chunk_i.first;
            // zeros past the end are real data for slide-down
            pair_q.high_valid  <= ~chunk_i.last | is_down;
            pair_q.count_store <= chunk_i.count_store;
            pair_q.op_shift    <= chunk_i.op_shift;
            pair_q.first       <= chunk_i.first;
            pair_q.last        <= chunk_i.last;
            pair_q.op          <= chunk_i.op;
            pair_q.eew         <= chunk_i.eew;
            pair_q.vl          <= chunk_i.vl;
        end
    end

    assign pair_o = pair_q;

endmodule

// File: sld_result_asm.sv
/* builds one destination word per operation; wr_mask_o is only non-zero with wr_en_o,
   tail bytes past vl and slide-up bytes below the offset are left out of the mask */
module sld_result_asm (
    input  logic                           clk_i,
    input  logic                           async_rst_ni,
    input  sld_pkg::sld_pair_t             pair_i,
    output logic                           wr_en_o,
    output logic [sld_pkg::VREG_W-1:0]     wr_data_o,
    output logic [sld_pkg::VREG_W/8-1:0]   wr_mask_o
);

    localparam int unsigned RES_B = sld_pkg::SLD_OP_W / 8;

    logic [sld_pkg::SLD_OP_W-1:0]   result_d;
    logic [RES_B-1:0]               byte_valid;
    logic [RES_B-1:0]               vl_mask;
    logic [6:0]                     vl_bytes;
    logic [6:0]                     vl_limit;
    logic                           store_d;

    logic [sld_pkg::SLD_OP_W-1:0]   result_q;
    logic [RES_B-1:0]               resmsk_q;
    logic [1:0]                     pos_q;
    logic                           store_q;
    logic                           first_q;
    logic                           last_q;

    logic [sld_pkg::VREG_W-1:0]     vd_q;
    logic [sld_pkg::VREG_W/8-1:0]   vdmsk_q;
    logic [sld_pkg::VREG_W/8-1:0]   vdmsk_d;
    logic                           wr_en_q;

    //////////////////////////////
    // byte rotation

    // each result byte comes from the low operand, or from the high one past the shift
    always_comb begin
        logic [2:0] idx;
        for (int i = 0; i < RES_B; i++) begin
            idx = {1'b0, pair_i.op_shift} + 3'(i);
            if (idx < 3'(RES_B)) begin
                result_d[i*8 +: 8] = pair_i.low[idx[1:0]*8 +: 8];
                byte_valid[i]      = pair_i.low_valid;
            end else begin
                result_d[i*8 +: 8] = pair_i.high[idx[1:0]*8 +: 8];
                byte_valid[i]      = pair_i.high_valid;
            end
        end
    end

    // tail limit in bytes, capped at the register size
    always_comb begin
        unique case (pair_i.eew)
            sld_pkg::SEW_8:  vl_bytes = {2'b00, pair_i.vl};
            sld_pkg::SEW_16: vl_bytes = {1'b0, pair_i.vl, 1'b0};
            default:         vl_bytes = {pair_i.vl, 2'b00};
        endcase
        vl_limit = (vl_bytes > 7'd16) ? 7'd16 : vl_bytes;
    end

    always_comb begin
        logic [6:0] byte_pos;
        for (int i = 0; i < RES_B; i++) begin
            byte_pos   = {3'b000, pair_i.count_store.part.low, 2'(i)};
            vl_mask[i] = byte_pos < vl_limit;
        end
    end

    assign store_d = pair_i.valid & ~pair_i.count_store.part.ext
                     & ~pair_i.count_store.part.mul;

    //////////////////////////////
    // result register

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            store_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            store_q <= store_d;
            first_q <= pair_i.valid & pair_i.first;
            last_q  <= pair_i.valid & pair_i.last;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q <= result_d;
        resmsk_q <= byte_valid & vl_mask;
        pos_q    <= pair_i.count_store.part.low;
    end

    //////////////////////////////
    // destination word

    // the first chunk of an operation starts from an empty mask
    always_comb begin
        vdmsk_d = first_q ? '0 : vdmsk_q;
        if (store_q) begin
            vdmsk_d[pos_q*RES_B +: RES_B] = resmsk_q;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vdmsk_q <= '0;
            wr_en_q <= 1'b0;
        end else begin
            vdmsk_q <= vdmsk_d;
            wr_en_q <= last_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (store_q) begin
            vd_q[pos_q*sld_pkg::SLD_OP_W +: sld_pkg::SLD_OP_W] <= result_q;
        end
    end

    assign wr_en_o   = wr_en_q;
    assign wr_data_o = vd_q;
    assign wr_mask_o = wr_en_q ? vdmsk_q : '0;

endmodule

// File: sld_unit.sv
/* slide unit top; one write per accepted operation, in acceptance order,
   at a fixed latency after op_ack_o; no back-pressure on the write side */
module sld_unit (
    input  logic                           clk_i,
    input  logic                           async_rst_ni,
    input  logic                           op_rdy_i,
    input  sld_pkg::sld_op_e               op_i,
    input  sld_pkg::sld_sew_e              sew_i,
    input  logic [31:0]                    rs1_i,
    input  logic [sld_pkg::VL_W-1:0]       vl_i,
    input  logic [sld_pkg::VREG_W-1:0]     src_i,
    output logic                           op_ack_o,
    output logic                           wr_en_o,
    output logic [sld_pkg::VREG_W-1:0]     wr_data_o,
    output logic [sld_pkg::VREG_W/8-1:0]   wr_mask_o
);

    sld_pkg::sld_chunk_t  chunk;
    sld_pkg::sld_pair_t   pair;

    // operand sequencer
    sld_operand_seq u_seq (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .op_i         (op_i),
        .sew_i        (sew_i),
        .rs1_i        (rs1_i),
        .vl_i         (vl_i),
        .src_i        (src_i),
        .op_ack_o     (op_ack_o),
        .chunk_o      (chunk)
    );

    // operand window
    sld_operand_win u_win (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .chunk_i      (chunk),
        .pair_o       (pair)
    );

    // result assembly
    sld_result_asm u_asm (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .pair_i       (pair),
        .wr_en_o      (wr_en_o),
        .wr_data_o    (wr_data_o),
        .wr_mask_o    (wr_mask_o)
    );

endmodule

// File: sld_unit_chk.sv
/* bound into sld_unit; handshake and write rules only, no data checks */
module sld_unit_chk (
    input logic                           clk_i,
    input logic                           async_rst_ni,
    input logic                           op_rdy_i,
    input logic                           op_ack_o,
    input logic                           wr_en_o,
    input logic [sld_pkg::VREG_W/8-1:0]   wr_mask_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // an acknowledge needs a ready operation
    ack_needs_rdy: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) op_ack_o |-> op_rdy_i
    ) else $error("op_ack_o high while op_rdy_i is low");

    // each operation issues 8 chunks before the next one is taken
    ack_spacing: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) op_ack_o |=> !op_ack_o [*7]
    ) else $error("second op_ack_o within 7 cycles of the previous one");

    write_pulse: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) wr_en_o |=> !wr_en_o
    ) else $error("wr_en_o held for more than one cycle");

    mask_idle: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) !wr_en_o |-> (wr_mask_o == '0)
    ) else $error("wr_mask_o non-zero without wr_en_o");

endmodule

bind sld_unit sld_unit_chk u_chk (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .op_rdy_i     (op_rdy_i),
    .op_ack_o     (op_ack_o),
    .wr_en_o      (wr_en_o),
    .wr_mask_o    (wr_mask_o)
);

// File: tb_sld_unit.sv
/* runs the operations of sld_golden.txt back to back with op_rdy_i held high;
   expects exactly NUM_VEC lines and compares data only on bytes enabled by the golden mask */
module tb_sld_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VEC     = 16;
    localparam int RST_CYCLES  = 16;
    localparam int TIMEOUT_CYC = NUM_VEC * 40 + RST_CYCLES;

    typedef struct packed {
        logic                           op;
        logic [1:0]                     sew;
        logic [31:0]                    rs1;
        logic [sld_pkg::VL_W-1:0]       vl;
        logic [sld_pkg::VREG_W-1:0]     src;
        logic [sld_pkg::VREG_W-1:0]     data;
        logic [sld_pkg::VREG_W/8-1:0]   mask;
    } vec_t;

    logic                           clk_i;
    logic                           async_rst_ni;
    logic                           op_rdy_i;
    sld_pkg::sld_op_e               op_i;
    sld_pkg::sld_sew_e              sew_i;
    logic [31:0]                    rs1_i;
    logic [sld_pkg::VL_W-1:0]       vl_i;
    logic [sld_pkg::VREG_W-1:0]     src_i;
    logic                           op_ack_o;
    logic                           wr_en_o;
    logic [sld_pkg::VREG_W-1:0]     wr_data_o;
    logic [sld_pkg::VREG_W/8-1:0]   wr_mask_o;

    vec_t   vecs[$];
    string  names[$];
    int     exp_q[$];
    int     n_checked = 0;
    int     cyc = 0;

    sld_unit uut (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .op_i         (op_i),
        .sew_i        (sew_i),
        .rs1_i        (rs1_i),
        .vl_i         (vl_i),
        .src_i        (src_i),
        .op_ack_o     (op_ack_o),
        .wr_en_o      (wr_en_o),
        .wr_data_o    (wr_data_o),
        .wr_mask_o    (wr_mask_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    // one enable bit per byte of the destination word
    function automatic logic [sld_pkg::VREG_W-1:0] expand_mask(
        input logic [sld_pkg::VREG_W/8-1:0] m
    );
        logic [sld_pkg::VREG_W-1:0] bm;
        for (int b = 0; b < sld_pkg::VREG_W / 8; b++) begin
            bm[b*8 +: 8] = {8{m[b]}};
        end
        return bm;
    endfunction

    //////////////////////////////
    // golden file

    task automatic read_golden();
        int                           fd;
        int                           n;
        string                        line;
        vec_t                         v;
        logic                         op;
        logic [1:0]                   sew;
        logic [31:0]                  rs1;
        logic [sld_pkg::VL_W-1:0]     vl;
        logic [sld_pkg::VREG_W-1:0]   src;
        logic [sld_pkg::VREG_W-1:0]   data;
        logic [sld_pkg::VREG_W/8-1:0] mask;
        fd = $fopen("sld_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sld_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines start with #
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", op, sew, rs1, vl, src, data, mask);
                    if (n == 7) begin
                        v = '{op, sew, rs1, vl, src, data, mask};
                        vecs.push_back(v);
                        names.push_back($sformatf("vec%0d_%s_sew%0d_rs1_%0h_vl%0d",
                            vecs.size() - 1, op ? "down" : "up", 8 << sew, rs1, vl));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // stimulus

    task automatic drive_op(input vec_t v);
        op_rdy_i <= 1'b1;
        op_i     <= sld_pkg::sld_op_e'(v.op);
        sew_i    <= sld_pkg::sld_sew_e'(v.sew);
        rs1_i    <= v.rs1;
        vl_i     <= v.vl;
        src_i    <= v.src;
    endtask

    initial begin
        op_rdy_i     = 1'b0;
        op_i         = sld_pkg::SLD_UP;
        sew_i        = sld_pkg::SEW_8;
        rs1_i        = '0;
        vl_i         = '0;
        src_i        = '0;
        async_rst_ni = 1'b0;
        read_golden();
        assert (vecs.size() == NUM_VEC)
            else abort_run($sformatf("golden file holds %0d vectors instead of %0d",
                                     vecs.size(), NUM_VEC));
        repeat (RST_CYCLES) @(posedge clk_i);
        async_rst_ni <= 1'b1;

        // nothing may move before the first operation
        repeat (4) begin
            @(negedge clk_i);
            assert (!op_ack_o && !wr_en_o)
                else abort_run("op_ack_o or wr_en_o went high before any operation");
        end

        @(posedge clk_i);
        foreach (vecs[i]) begin
            drive_op(vecs[i]);
            do begin
                @(negedge clk_i);
            end while (!op_ack_o);
            exp_q.push_back(i);
            // accepted on this edge, the next operation follows at once
            @(posedge clk_i);
        end
        op_rdy_i <= 1'b0;

        wait (n_checked == vecs.size());
        repeat (4) @(negedge clk_i);
        $display("Regression passed");
        $finish;
    end

    //////////////////////////////
    // write checks

    task automatic check_write();
        int                         idx;
        vec_t                       v;
        logic [sld_pkg::VREG_W-1:0] bm;
        if (exp_q.size() == 0) begin
            abort_run("wr_en_o pulsed with no operation pending");
        end else begin
            idx = exp_q.pop_front();
            v   = vecs[idx];
            bm  = expand_mask(v.mask);
            assert (wr_mask_o == v.mask)
                else abort_run($sformatf("CHECK FAILED %s wr_mask_o expected %h actual %h",
                                         names[idx], v.mask, wr_mask_o));
            assert ((wr_data_o & bm) == (v.data & bm))
                else abort_run($sformatf("CHECK FAILED %s wr_data_o expected %h actual %h",
                                         names[idx], v.data & bm, wr_data_o & bm));
            n_checked++;
        end
    endtask

    always @(negedge clk_i) begin
        if (async_rst_ni && wr_en_o) begin
            check_write();
        end
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d writes seen",
                                cyc, n_checked, NUM_VEC));
        end
    end

endmodule

// File: sld_golden.txt
# op(0 up, 1 down) sew(0=8, 1=16, 2=32) rs1 vl src expected_data expected_mask
# all columns hex, vectors written byte 15 first, data outside the mask is 0
0 0 3 10 0f0e0d0c0b0a09080706050403020100 0c0b0a09080706050403020100000000 fff8
0 1 2 8 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 abaaa9a8a7a6a5a4a3a2a1a000000000 fff0
0 2 1 3 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 00000000f8f9fafbfcfdfeff00000000 0ff0
0 0 9 d 0f0e0d0c0b0a09080706050403020100 00000003020100000000000000000000 1e00
0 1 5 8 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 a5a4a3a2a1a000000000000000000000 fc00
1 0 3 10 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000afaeadacabaaa9a8a7a6a5a4a3 ffff
1 2 2 4 0f0e0d0c0b0a09080706050403020100 00000000000000000f0e0d0c0b0a0908 ffff
1 1 7 8 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0000000000000000000000000000f0f1 ffff
1 0 1 5 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0000000000000000000000fafbfcfdfe 001f
0 0 0 0 0f0e0d0c0b0a09080706050403020100 0 0000
1 1 0 0 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0 0000
0 0 10 10 0f0e0d0c0b0a09080706050403020100 0 0000
1 2 80000001 4 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0 ffff
1 1 8 3 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0 003f
0 2 3 4 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff fcfdfeff000000000000000000000000 f000
1 2 1 2 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0000000000000000f4f5f6f7f8f9fafb 00ff

// File: files.f
sld_pkg.sv
sld_operand_seq.sv
sld_operand_win.sv
sld_result_asm.sv
sld_unit.sv
sld_unit_chk.sv
tb_sld_unit.sv

// File: Bender.yml
package:
  name: sld_unit

sources:
  - sld_pkg.sv
  - sld_operand_seq.sv
  - sld_operand_win.sv
  - sld_result_asm.sv
  - sld_unit.sv
  - target: test
    files:
      - sld_unit_chk.sv
      - tb_sld_unit.sv
